//--- source/ctrl_pkg.sv
package ctrl_pkg;

	// ----------------------------------------
	// spi frame
	// ----------------------------------------
	localparam int SPI_CMD_LENGTH  = 8;       // command bits
	localparam int SPI_ADDR_LENGTH = 16;      // address bits
	localparam int SPI_DATA_LENGTH = 16;      // data bits
	localparam int SPI_CNT_WIDTH   = 5;       // bit counter, covers the longest phase
	localparam logic [7:0] SPI_CMD_WR = 8'h80;  // write frame
	localparam logic [7:0] SPI_CMD_RD = 8'h81;  // read frame

	// ----------------------------------------
	// field widths
	// ----------------------------------------
	localparam int TIMESTAMP_WIDTH   = 64;
	localparam int TRIG_SOURCE_WIDTH = 4;
	localparam int TRIG_FILTER_WIDTH = 19;    // split over _H and _L
	localparam int TRIG_DELAY_WIDTH  = 28;    // split over _H and _L
	localparam int LED_CTRL_WIDTH    = 5;
	localparam int LINE_WIDTH        = 4;     // one bit per line
	localparam int IRQ_WIDTH         = 2;     // one bit per interrupt
	localparam int USEROUT_WIDTH     = 3;     // user output level

	typedef logic [SPI_ADDR_LENGTH-1:0]   reg_addr_t;
	typedef logic [SPI_DATA_LENGTH-1:0]   reg_data_t;
	typedef logic [SPI_CMD_LENGTH-1:0]    spi_cmd_t;
	typedef logic [TIMESTAMP_WIDTH-1:0]   timestamp_t;
	typedef logic [TRIG_SOURCE_WIDTH-1:0] trig_source_t;
	typedef logic [TRIG_FILTER_WIDTH-1:0] trig_filter_t;
	typedef logic [TRIG_DELAY_WIDTH-1:0]  trig_delay_t;
	typedef logic [LED_CTRL_WIDTH-1:0]    led_ctrl_t;
	typedef logic [LINE_WIDTH-1:0]        line_status_t;
	typedef logic [IRQ_WIDTH-1:0]         irq_t;

	typedef enum logic [2:0] {
		SPI_IDLE,  // cs high
		SPI_CMD,   // command bits
		SPI_ADDR,  // address bits
		SPI_DATA,  // write data in or read data out
		SPI_SKIP   // ignore the rest of the frame
	} spi_state_e;

	// ----------------------------------------
	// register address map
	// ----------------------------------------
	localparam reg_addr_t ADDR_STREAM_EN         = 16'h0010;  // bit0 stream, bit1 acq start
	localparam reg_addr_t ADDR_TRIG_MODE         = 16'h0020;
	localparam reg_addr_t ADDR_TRIG_SOURCE       = 16'h0021;
	localparam reg_addr_t ADDR_TRIG_SOFT         = 16'h0022;  // write only, pulse
	localparam reg_addr_t ADDR_TRIG_ACTIVE       = 16'h0023;
	localparam reg_addr_t ADDR_TRIG_FILTER_RISE_H = 16'h0024;
	localparam reg_addr_t ADDR_TRIG_FILTER_RISE_L = 16'h0025;
	localparam reg_addr_t ADDR_TRIG_FILTER_FALL_H = 16'h0026;
	localparam reg_addr_t ADDR_TRIG_FILTER_FALL_L = 16'h0027;
	localparam reg_addr_t ADDR_TRIG_DELAY_H      = 16'h0028;
	localparam reg_addr_t ADDR_TRIG_DELAY_L      = 16'h0029;
	localparam reg_addr_t ADDR_USEROUTPUT        = 16'h0030;
	localparam reg_addr_t ADDR_LED_CTRL          = 16'h0031;
	localparam reg_addr_t ADDR_LINE_STATUS       = 16'h0032;  // read only
	localparam reg_addr_t ADDR_INT_EN            = 16'h0040;
	localparam reg_addr_t ADDR_INT_STATE         = 16'h0041;  // read only
	localparam reg_addr_t ADDR_INT_CLEAR         = 16'h0042;  // write only, pulse
	localparam reg_addr_t ADDR_TS_LOAD           = 16'h0050;  // any write captures
	localparam reg_addr_t ADDR_TS_0              = 16'h0051;  // low word
	localparam reg_addr_t ADDR_TS_1              = 16'h0052;
	localparam reg_addr_t ADDR_TS_2              = 16'h0053;
	localparam reg_addr_t ADDR_TS_3              = 16'h0054;  // high word

endpackage

//--- source/reg_bus_if.sv
interface reg_bus_if import ctrl_pkg::*; ();

	logic      wr_en;    // one cycle write strobe
	logic      rd_en;    // one cycle read strobe
	reg_addr_t addr;     // register address
	reg_data_t wr_data;  // write word
	reg_data_t rd_data;  // registered, valid the cycle after rd_en

	// spi slave issues the accesses
	modport spi_side (
		output wr_en,
		output rd_en,
		output addr,
		output wr_data,
		input  rd_data
	);

	// register bank takes every strobe, no back-pressure
	modport reg_side (
		input  wr_en,
		input  rd_en,
		input  addr,
		input  wr_data,
		output rd_data
	);

endinterface

//--- source/spi_slave.sv
module spi_slave import ctrl_pkg::*; (
	input  logic        clk_gpif,            // also the spi sampling clock
	input  logic        i_reset,
	input  logic        i_spi_clk,           // idle low, sampled on rise
	input  logic        i_spi_cs_n,          // low for a frame
	input  logic        i_spi_mosi,
	output logic        o_spi_miso_data,
	output logic        o_spi_miso_data_en,  // 1 while read data is driven
	reg_bus_if.spi_side bus
);

	// ----------------------------------------
	// pin sync and edge detect
	// ----------------------------------------
	logic [2:0] sclk_sync;  // two sync flops plus history
	logic [1:0] cs_sync;
	logic [1:0] mosi_sync;
	logic       cs_high;    // frame ended or not started
	logic       bit_rise;   // rising spi clock inside a frame
	logic       bit_fall;

	always_ff @(posedge clk_gpif) begin
		if (i_reset) begin
			sclk_sync <= '0;
			cs_sync   <= '1;
		end else begin
			sclk_sync <= {sclk_sync[1:0], i_spi_clk};
			cs_sync   <= {cs_sync[0], i_spi_cs_n};
		end
	end

	always_ff @(posedge clk_gpif) begin
		mosi_sync <= {mosi_sync[0], i_spi_mosi};  // aligned with sclk_sync[1]
	end

	assign cs_high  = cs_sync[1];
	assign bit_rise = sclk_sync[1] & ~sclk_sync[2] & ~cs_high;
	assign bit_fall = ~sclk_sync[1] & sclk_sync[2] & ~cs_high;

	// ----------------------------------------
	// frame decode
	// ----------------------------------------
	spi_state_e               state;
	logic [SPI_CNT_WIDTH-1:0] bit_cnt;     // bits seen in current phase
	reg_data_t                shift_reg;   // mosi deserializer
	reg_data_t                shift_next;  // shift_reg with the bit being sampled
	spi_cmd_t                 cmd_word;
	logic                     cmd_done;
	logic                     addr_done;
	logic                     data_done;
	logic                     rd_frame;    // current frame is a read
	logic                     rd_pend;     // rd_en delayed, rd_data valid now
	logic                     miso_shift_en;
	reg_data_t                miso_shift;

	assign shift_next = {shift_reg[SPI_DATA_LENGTH-2:0], mosi_sync[1]};
	assign cmd_word   = shift_next[SPI_CMD_LENGTH-1:0];
	assign cmd_done   = bit_rise && state == SPI_CMD &&
		bit_cnt == SPI_CNT_WIDTH'(SPI_CMD_LENGTH - 1);
	assign addr_done  = bit_rise && state == SPI_ADDR &&
		bit_cnt == SPI_CNT_WIDTH'(SPI_ADDR_LENGTH - 1);
	assign data_done  = bit_rise && state == SPI_DATA &&
		bit_cnt == SPI_CNT_WIDTH'(SPI_DATA_LENGTH - 1);

	always_ff @(posedge clk_gpif) begin
		if (i_reset) begin
			state      <= SPI_IDLE;
			bit_cnt    <= '0;
			rd_frame   <= 1'b0;
			bus.wr_en  <= 1'b0;
			bus.rd_en  <= 1'b0;
		end else begin
			bus.wr_en <= 1'b0;  // strobes by default low
			bus.rd_en <= 1'b0;
			if (cs_high || cmd_done || addr_done || data_done)
				bit_cnt <= '0;  // new phase
			else if (bit_rise)
				bit_cnt <= bit_cnt + 1'b1;
			if (cs_high) begin
				state <= SPI_IDLE;  // abort at any point, no strobe
			end else begin
				case (state)
					SPI_IDLE: state <= SPI_CMD;
					SPI_CMD: if (cmd_done) begin
						rd_frame <= (cmd_word == SPI_CMD_RD);
						if (cmd_word == SPI_CMD_WR || cmd_word == SPI_CMD_RD)
							state <= SPI_ADDR;
						else
							state <= SPI_SKIP;  // unknown command
					end
					SPI_ADDR: if (addr_done) begin
						state     <= SPI_DATA;
						bus.rd_en <= rd_frame;  // fetch word now
					end
					SPI_DATA: if (data_done) begin
						state     <= SPI_SKIP;
						bus.wr_en <= ~rd_frame;  // last data bit in
					end
					default: ;  // skip until cs rises
				endcase
			end
		end
	end

	// ----------------------------------------
	// read data out
	// ----------------------------------------
	// first fall after the last address bit keeps the msb on the line
	assign miso_shift_en = bit_fall && rd_frame && state == SPI_DATA && bit_cnt != '0;

	always_ff @(posedge clk_gpif) begin
		if (i_reset) begin
			rd_pend            <= 1'b0;
			o_spi_miso_data_en <= 1'b0;
		end else begin
			rd_pend <= bus.rd_en;
			if (cs_high)
				o_spi_miso_data_en <= 1'b0;  // released at frame end
			else if (rd_pend)
				o_spi_miso_data_en <= 1'b1;
		end
	end

	always_ff @(posedge clk_gpif) begin
		if (bit_rise)
			shift_reg <= shift_next;
		if (addr_done)
			bus.addr <= shift_next;
		if (rd_pend)
			miso_shift <= bus.rd_data;  // 2 cycles after rd_en
		else if (miso_shift_en)
			miso_shift <= {miso_shift[SPI_DATA_LENGTH-2:0], 1'b0};
	end

	assign bus.wr_data     = shift_reg;  // complete when wr_en is high
	assign o_spi_miso_data = miso_shift[SPI_DATA_LENGTH-1];  // msb first

endmodule

//--- source/ctrl_reg_bank.sv
module ctrl_reg_bank import ctrl_pkg::*; (
	input  logic                     clk_gpif,
	input  logic                     i_reset,
	reg_bus_if.reg_side              bus,
	input  line_status_t             i_line_status,      // live line levels
	input  irq_t                     i_interrupt_state,
	input  timestamp_t               i_timestamp_reg,    // captured on load
	output logic                     o_timestamp_load,   // one cycle pulse
	output logic                     o_stream_enable,
	output logic                     o_acquisition_start,
	output logic                     o_trigger_mode,
	output logic                     o_trigger_active,   // active edge select
	output logic                     o_trigger_soft,     // one cycle pulse
	output trig_source_t             o_trigger_source,
	output trig_filter_t             o_trigger_filter_rise,
	output trig_filter_t             o_trigger_filter_fall,
	output trig_delay_t              o_trigger_delay,
	output logic [USEROUT_WIDTH-1:0] o_useroutput_level,
	output led_ctrl_t                o_led_ctrl,
	output irq_t                     o_interrupt_en,
	output irq_t                     o_interrupt_clear   // one cycle, written bits
);

	// ----------------------------------------
	// write decode
	// ----------------------------------------
	always_ff @(posedge clk_gpif) begin
		if (i_reset) begin
			o_stream_enable       <= 1'b0;
			o_acquisition_start   <= 1'b0;
			o_trigger_mode        <= 1'b0;
			o_trigger_active      <= 1'b0;
			o_trigger_source      <= '0;
			o_trigger_filter_rise <= '0;
			o_trigger_filter_fall <= '0;
			o_trigger_delay       <= '0;
			o_useroutput_level    <= '0;
			o_led_ctrl            <= '0;
			o_interrupt_en        <= '0;
			o_trigger_soft        <= 1'b0;
			o_interrupt_clear     <= '0;
			o_timestamp_load      <= 1'b0;
		end else begin
			o_trigger_soft    <= 1'b0;  // pulses fall back
			o_interrupt_clear <= '0;
			o_timestamp_load  <= 1'b0;
			if (bus.wr_en) begin
				case (bus.addr)
					ADDR_STREAM_EN: begin
						o_stream_enable     <= bus.wr_data[0];
						o_acquisition_start <= bus.wr_data[1];
					end
					ADDR_TRIG_MODE:   o_trigger_mode   <= bus.wr_data[0];
					ADDR_TRIG_SOURCE: o_trigger_source <= bus.wr_data[TRIG_SOURCE_WIDTH-1:0];
					ADDR_TRIG_SOFT:   o_trigger_soft   <= 1'b1;  // any write fires
					ADDR_TRIG_ACTIVE: o_trigger_active <= bus.wr_data[0];
					ADDR_TRIG_FILTER_RISE_H: o_trigger_filter_rise[TRIG_FILTER_WIDTH-1:16] <=
						bus.wr_data[TRIG_FILTER_WIDTH-17:0];  // upper bits right-aligned
					ADDR_TRIG_FILTER_RISE_L: o_trigger_filter_rise[15:0] <= bus.wr_data;
					ADDR_TRIG_FILTER_FALL_H: o_trigger_filter_fall[TRIG_FILTER_WIDTH-1:16] <=
						bus.wr_data[TRIG_FILTER_WIDTH-17:0];
					ADDR_TRIG_FILTER_FALL_L: o_trigger_filter_fall[15:0] <= bus.wr_data;
					ADDR_TRIG_DELAY_H: o_trigger_delay[TRIG_DELAY_WIDTH-1:16] <=
						bus.wr_data[TRIG_DELAY_WIDTH-17:0];
					ADDR_TRIG_DELAY_L: o_trigger_delay[15:0] <= bus.wr_data;
					ADDR_USEROUTPUT:   o_useroutput_level <= bus.wr_data[USEROUT_WIDTH-1:0];
					ADDR_LED_CTRL:     o_led_ctrl         <= bus.wr_data[LED_CTRL_WIDTH-1:0];
					ADDR_INT_EN:       o_interrupt_en     <= bus.wr_data[IRQ_WIDTH-1:0];
					ADDR_INT_CLEAR:    o_interrupt_clear  <= bus.wr_data[IRQ_WIDTH-1:0];
					ADDR_TS_LOAD:      o_timestamp_load   <= 1'b1;  // capture counter
					default: ;  // read only or unmapped, ignored
				endcase
			end
		end
	end

	// ----------------------------------------
	// read mux, registered
	// ----------------------------------------
	always_ff @(posedge clk_gpif) begin
		if (bus.rd_en) begin
			case (bus.addr)
				ADDR_STREAM_EN:
					bus.rd_data <= reg_data_t'({o_acquisition_start, o_stream_enable});
				ADDR_TRIG_MODE:   bus.rd_data <= reg_data_t'(o_trigger_mode);
				ADDR_TRIG_SOURCE: bus.rd_data <= reg_data_t'(o_trigger_source);
				ADDR_TRIG_ACTIVE: bus.rd_data <= reg_data_t'(o_trigger_active);
				ADDR_TRIG_FILTER_RISE_H:
					bus.rd_data <= reg_data_t'(o_trigger_filter_rise[TRIG_FILTER_WIDTH-1:16]);
				ADDR_TRIG_FILTER_RISE_L: bus.rd_data <= o_trigger_filter_rise[15:0];
				ADDR_TRIG_FILTER_FALL_H:
					bus.rd_data <= reg_data_t'(o_trigger_filter_fall[TRIG_FILTER_WIDTH-1:16]);
				ADDR_TRIG_FILTER_FALL_L: bus.rd_data <= o_trigger_filter_fall[15:0];
				ADDR_TRIG_DELAY_H:
					bus.rd_data <= reg_data_t'(o_trigger_delay[TRIG_DELAY_WIDTH-1:16]);
				ADDR_TRIG_DELAY_L: bus.rd_data <= o_trigger_delay[15:0];
				ADDR_USEROUTPUT:   bus.rd_data <= reg_data_t'(o_useroutput_level);
				ADDR_LED_CTRL:     bus.rd_data <= reg_data_t'(o_led_ctrl);
				ADDR_LINE_STATUS:  bus.rd_data <= reg_data_t'(i_line_status);      // live
				ADDR_INT_EN:       bus.rd_data <= reg_data_t'(o_interrupt_en);
				ADDR_INT_STATE:    bus.rd_data <= reg_data_t'(i_interrupt_state);  // live
				ADDR_TS_0:         bus.rd_data <= i_timestamp_reg[15:0];
				ADDR_TS_1:         bus.rd_data <= i_timestamp_reg[31:16];
				ADDR_TS_2:         bus.rd_data <= i_timestamp_reg[47:32];
				ADDR_TS_3:         bus.rd_data <= i_timestamp_reg[63:48];
				default:           bus.rd_data <= '0;  // write only and unmapped
			endcase
		end
	end

endmodule

//--- source/timestamp.sv
module timestamp import ctrl_pkg::*; (
	input  logic       clk_gpif,
	input  logic       i_reset,
	input  logic       i_fval,            // frame valid, same clock domain
	input  logic       i_timestamp_load,  // capture request from register bank
	output timestamp_t o_timestamp_u3,    // latched at frame start, for the header
	output timestamp_t o_timestamp_reg    // latched on load, for spi readout
);

	timestamp_t ts_cnt;   // free running
	logic       fval_d;   // history for edge detect
	logic       fval_rise;

	// ----------------------------------------
	// counter and frame edge
	// ----------------------------------------
	always_ff @(posedge clk_gpif) begin
		if (i_reset) begin
			ts_cnt <= '0;
			fval_d <= 1'b0;
		end else begin
			ts_cnt <= ts_cnt + 1'b1;  // one tick per cycle
			fval_d <= i_fval;
		end
	end

	assign fval_rise = i_fval & ~fval_d;

	// ----------------------------------------
	// latches
	// ----------------------------------------
	always_ff @(posedge clk_gpif) begin
		if (fval_rise)
			o_timestamp_u3 <= ts_cnt;   // valid the cycle after the rise
		if (i_timestamp_load)
			o_timestamp_reg <= ts_cnt;  // held until the next load
	end

endmodule

//--- source/ctrl_channel.sv
module ctrl_channel import ctrl_pkg::*; (
	input  logic                     clk_gpif,               // system and spi sampling clock
	input  logic                     i_reset,
	// spi pins
	input  logic                     i_spi_clk,
	input  logic                     i_spi_cs_n,
	input  logic                     i_spi_mosi,
	output logic                     o_spi_miso_data,
	output logic                     o_spi_miso_data_en,
	// status in
	input  logic                     i_fval,
	input  line_status_t             i_line_status,
	input  irq_t                     i_interrupt_state,
	// controls out
	output logic                     o_stream_enable,
	output logic                     o_acquisition_start,
	output logic                     o_trigger_mode,
	output logic                     o_trigger_active,
	output logic                     o_trigger_soft,
	output trig_source_t             o_trigger_source,
	output trig_filter_t             o_trigger_filter_rise,
	output trig_filter_t             o_trigger_filter_fall,
	output trig_delay_t              o_trigger_delay,
	output logic [USEROUT_WIDTH-1:0] o_useroutput_level,
	output led_ctrl_t                o_led_ctrl,
	output irq_t                     o_interrupt_en,
	output irq_t                     o_interrupt_clear,
	output timestamp_t               o_timestamp_u3          // frame start time
);

	reg_bus_if  reg_bus ();       // spi to register bank
	logic       timestamp_load;   // bank to counter
	timestamp_t timestamp_reg;    // counter to bank

	spi_slave i_spi_slave (
		.clk_gpif           (clk_gpif),
		.i_reset            (i_reset),
		.i_spi_clk          (i_spi_clk),
		.i_spi_cs_n         (i_spi_cs_n),
		.i_spi_mosi         (i_spi_mosi),
		.o_spi_miso_data    (o_spi_miso_data),
		.o_spi_miso_data_en (o_spi_miso_data_en),
		.bus                (reg_bus)
	);

	ctrl_reg_bank i_ctrl_reg_bank (
		.clk_gpif              (clk_gpif),
		.i_reset               (i_reset),
		.bus                   (reg_bus),
		.i_line_status         (i_line_status),
		.i_interrupt_state     (i_interrupt_state),
		.i_timestamp_reg       (timestamp_reg),
		.o_timestamp_load      (timestamp_load),
		.o_stream_enable       (o_stream_enable),
		.o_acquisition_start   (o_acquisition_start),
		.o_trigger_mode        (o_trigger_mode),
		.o_trigger_active      (o_trigger_active),
		.o_trigger_soft        (o_trigger_soft),
		.o_trigger_source      (o_trigger_source),
		.o_trigger_filter_rise (o_trigger_filter_rise),
		.o_trigger_filter_fall (o_trigger_filter_fall),
		.o_trigger_delay       (o_trigger_delay),
		.o_useroutput_level    (o_useroutput_level),
		.o_led_ctrl            (o_led_ctrl),
		.o_interrupt_en        (o_interrupt_en),
		.o_interrupt_clear     (o_interrupt_clear)
	);

	timestamp i_timestamp (
		.clk_gpif         (clk_gpif),
		.i_reset          (i_reset),
		.i_fval           (i_fval),
		.i_timestamp_load (timestamp_load),
		.o_timestamp_u3   (o_timestamp_u3),
		.o_timestamp_reg  (timestamp_reg)
	);

endmodule

//--- tb/spi_master.svh
`ifndef SPI_MASTER_SVH
`define SPI_MASTER_SVH

localparam int SPI_HALF = 6;  // clk_gpif cycles per spi half period

logic [31:0] rng_state = 32'h44018cc9;

function automatic logic [31:0] xorshift();
	logic [31:0] x;
	x = rng_state;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	rng_state = x;
	return x;
endfunction

// one spi bit, low half then high half, called on a falling clk_gpif edge
task automatic shift_bit(input logic mosi_bit, output logic miso_bit);
	i_spi_clk  = 1'b0;
	i_spi_mosi = mosi_bit;  // master changes mosi while sclk is low
	repeat (SPI_HALF) @(negedge clk_gpif);
	miso_bit  = o_spi_miso_data;  // settled before the rise
	i_spi_clk = 1'b1;
	repeat (SPI_HALF) @(negedge clk_gpif);
endtask

task automatic send_header(input spi_cmd_t cmd, input reg_addr_t addr);
	logic miso_bit;
	i_spi_cs_n = 1'b0;  // frame open
	for (int i = SPI_CMD_LENGTH - 1; i >= 0; i--)
		shift_bit(cmd[i], miso_bit);  // msb first
	for (int i = SPI_ADDR_LENGTH - 1; i >= 0; i--)
		shift_bit(addr[i], miso_bit);
endtask

task automatic end_frame();
	i_spi_clk = 1'b0;
	repeat (SPI_HALF) @(negedge clk_gpif);
	i_spi_cs_n = 1'b1;
	repeat (2 * SPI_HALF) @(negedge clk_gpif);  // idle gap between frames
endtask

task automatic spi_write(input reg_addr_t addr, input reg_data_t data);
	logic miso_bit;
	send_header(SPI_CMD_WR, addr);
	for (int i = SPI_DATA_LENGTH - 1; i >= 0; i--)
		shift_bit(data[i], miso_bit);
	end_frame();
endtask

task automatic spi_read(input reg_addr_t addr, output reg_data_t data);
	logic miso_bit;
	send_header(SPI_CMD_RD, addr);
	for (int i = SPI_DATA_LENGTH - 1; i >= 0; i--) begin
		shift_bit(1'b0, miso_bit);
		data[i] = miso_bit;
	end
	if (!o_spi_miso_data_en)
		report_fail($sformatf("MISO enable low during read data of %h", addr));
	end_frame();
	if (o_spi_miso_data_en)
		report_fail($sformatf("MISO enable still high after read frame of %h", addr));
endtask

// write frame cut after the address bits
task automatic cut_frame(input reg_addr_t addr);
	send_header(SPI_CMD_WR, addr);
	end_frame();
endtask

`endif

//--- tb/ctrl_channel_tb.sv
module ctrl_channel_tb import ctrl_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	logic                     clk_gpif = 1'b0;
	logic                     i_reset;
	logic                     i_spi_clk, i_spi_cs_n, i_spi_mosi;
	logic                     i_fval;
	line_status_t             i_line_status;
	irq_t                     i_interrupt_state;
	logic                     o_spi_miso_data, o_spi_miso_data_en;
	logic                     o_stream_enable, o_acquisition_start;
	logic                     o_trigger_mode, o_trigger_active, o_trigger_soft;
	trig_source_t             o_trigger_source;
	trig_filter_t             o_trigger_filter_rise, o_trigger_filter_fall;
	trig_delay_t              o_trigger_delay;
	logic [USEROUT_WIDTH-1:0] o_useroutput_level;
	led_ctrl_t                o_led_ctrl;
	irq_t                     o_interrupt_en, o_interrupt_clear;
	timestamp_t               o_timestamp_u3;

	ctrl_channel i_dut (.*);

	always #4 clk_gpif = ~clk_gpif;  // 8 ns period

	// ----------------------------------------
	// failure and compares
	// ----------------------------------------
	task automatic report_fail(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic compare_data(input string name, input reg_data_t exp_val, input reg_data_t act);
		if (act !== exp_val)
			report_fail($sformatf("Mismatch %s expected %h actual %h", name, exp_val, act));
	endtask

	task automatic compare_irq(input string name, input irq_t exp_val, input irq_t act);
		if (act !== exp_val)
			report_fail($sformatf("Mismatch %s expected %b actual %b", name, exp_val, act));
	endtask

	task automatic compare_ts(input string name, input timestamp_t exp_val, input timestamp_t act);
		if (act !== exp_val)
			report_fail($sformatf("Mismatch %s expected %0d actual %0d", name, exp_val, act));
	endtask

	`include "spi_master.svh"

	// ----------------------------------------
	// stimulus table
	// ----------------------------------------
	typedef enum {OP_WRITE, OP_READ, OP_PULSE, OP_ABORT, OP_TS} op_e;
	typedef struct {
		string     name;
		op_e       op;
		reg_addr_t addr;
		reg_data_t data;
		reg_data_t exp_val;  // port word, read word or pulse value
	} test_t;

	localparam int        N_CTRL = 13;
	localparam reg_addr_t CTRL_ADDR [N_CTRL] = '{ADDR_STREAM_EN, ADDR_TRIG_MODE,
		ADDR_TRIG_SOURCE, ADDR_TRIG_ACTIVE, ADDR_TRIG_FILTER_RISE_H, ADDR_TRIG_FILTER_RISE_L,
		ADDR_TRIG_FILTER_FALL_H, ADDR_TRIG_FILTER_FALL_L, ADDR_TRIG_DELAY_H,
		ADDR_TRIG_DELAY_L, ADDR_USEROUTPUT, ADDR_LED_CTRL, ADDR_INT_EN};
	// writable bits per register with the upper field bits in the _H halves
	localparam reg_data_t CTRL_MASK [N_CTRL] = '{16'h0003, 16'h0001, 16'h000f, 16'h0001,
		16'h0007, 16'hffff, 16'h0007, 16'hffff, 16'h0fff, 16'hffff, 16'h0007, 16'h001f,
		16'h0003};
	localparam int        FRAME_CYCLES = 40 * 2 * SPI_HALF;  // one full write frame

	test_t      tests[$];
	reg_data_t  port_exp [N_CTRL] = '{default: '0};  // port words after the writes so far
	int         run_len = 0;
	timestamp_t cycles;           // cycles since reset
	int         soft_total = 0;
	int         clear_total = 0;
	irq_t       clear_last = '0;  // bits of the last clear pulse

	always @(posedge clk_gpif) begin
		if (i_reset)
			cycles <= '0;
		else
			cycles <= cycles + 1'b1;
		if (o_trigger_soft)
			soft_total <= soft_total + 1;  // one count per high cycle
		if (o_interrupt_clear != '0) begin
			clear_total <= clear_total + 1;
			clear_last  <= o_interrupt_clear;
		end
	end

	function automatic reg_data_t port_word(reg_addr_t a);
		case (a)
			ADDR_STREAM_EN:          return reg_data_t'({o_acquisition_start, o_stream_enable});
			ADDR_TRIG_MODE:          return reg_data_t'(o_trigger_mode);
			ADDR_TRIG_SOURCE:        return reg_data_t'(o_trigger_source);
			ADDR_TRIG_ACTIVE:        return reg_data_t'(o_trigger_active);
			ADDR_TRIG_FILTER_RISE_H: return reg_data_t'(o_trigger_filter_rise >> 16);
			ADDR_TRIG_FILTER_RISE_L: return o_trigger_filter_rise[15:0];
			ADDR_TRIG_FILTER_FALL_H: return reg_data_t'(o_trigger_filter_fall >> 16);
			ADDR_TRIG_FILTER_FALL_L: return o_trigger_filter_fall[15:0];
			ADDR_TRIG_DELAY_H:       return reg_data_t'(o_trigger_delay >> 16);
			ADDR_TRIG_DELAY_L:       return o_trigger_delay[15:0];
			ADDR_USEROUTPUT:         return reg_data_t'(o_useroutput_level);
			ADDR_LED_CTRL:           return reg_data_t'(o_led_ctrl);
			ADDR_INT_EN:             return reg_data_t'(o_interrupt_en);
			default:                 return '0;  // no port behind it
		endcase
	endfunction

	task automatic add_test(input string name, input op_e op, input reg_addr_t addr,
			input reg_data_t data, input reg_data_t exp_val);
		tests.push_back(test_t'{name, op, addr, data, exp_val});
	endtask

	task automatic build_table();
		reg_data_t r;
		reg_data_t wr_val [N_CTRL];
		for (int i = 0; i < N_CTRL; i++)
			add_test($sformatf("reset read %h", CTRL_ADDR[i]), OP_READ, CTRL_ADDR[i], '0, '0);
		for (int i = 0; i < N_CTRL; i++) begin
			r = reg_data_t'(xorshift());  // full word of which the dut keeps the field bits
			wr_val[i] = r & CTRL_MASK[i];
			add_test($sformatf("write %h", CTRL_ADDR[i]), OP_WRITE, CTRL_ADDR[i], r, wr_val[i]);
		end
		for (int i = 0; i < N_CTRL; i++)
			add_test($sformatf("readback %h", CTRL_ADDR[i]), OP_READ, CTRL_ADDR[i], '0, wr_val[i]);
		add_test("unmapped read", OP_READ, 16'h0077, '0, '0);
		add_test("soft trigger read", OP_READ, ADDR_TRIG_SOFT, '0, '0);  // write only
		add_test("line status write", OP_WRITE, ADDR_LINE_STATUS, reg_data_t'(xorshift()), '0);
		add_test("line status", OP_READ, ADDR_LINE_STATUS, '0, reg_data_t'(i_line_status));
		add_test("interrupt state", OP_READ, ADDR_INT_STATE, '0, reg_data_t'(i_interrupt_state));
		add_test("unmapped write", OP_WRITE, 16'h00f0, reg_data_t'(xorshift()), '0);
		add_test("unmapped readback", OP_READ, 16'h00f0, '0, '0);
		add_test("soft trigger", OP_PULSE, ADDR_TRIG_SOFT, reg_data_t'(xorshift()), 16'd1);
		r = reg_data_t'(xorshift()) | 16'h0001;  // at least one bit to clear
		add_test("interrupt clear", OP_PULSE, ADDR_INT_CLEAR, r, r & 16'h0003);
		add_test("aborted write", OP_ABORT, ADDR_LED_CTRL, '0, '0);
		add_test("led after abort", OP_READ, ADDR_LED_CTRL, '0, wr_val[11]);
		add_test("timestamp", OP_TS, ADDR_TS_LOAD, '0, '0);
	endtask

	// ----------------------------------------
	// timestamp checks
	// ----------------------------------------
	task automatic capture_timestamp(output timestamp_t ts);
		reg_data_t w;
		spi_write(ADDR_TS_LOAD, reg_data_t'(xorshift()));  // any value captures
		for (int i = 0; i < 4; i++) begin
			spi_read(ADDR_TS_0 + reg_addr_t'(i), w);
			ts[16*i +: 16] = w;  // low word first
		end
	endtask

	task automatic check_timestamp(input string name);
		timestamp_t first;
		timestamp_t frame_ts;
		timestamp_t second;
		timestamp_t u3_exp;
		capture_timestamp(first);
		if (first >= cycles)
			report_fail($sformatf("%s capture %0d not below %0d cycles since reset",
				name, first, cycles));
		i_fval = 1'b1;    // frame starts
		u3_exp = cycles;  // counter value seen by the next rising edge
		repeat (2) @(negedge clk_gpif);
		frame_ts = o_timestamp_u3;
		i_fval   = 1'b0;
		compare_ts(name, u3_exp, frame_ts);
		capture_timestamp(second);
		if (!(first < frame_ts && frame_ts < second))
			report_fail($sformatf("%s values not increasing %0d %0d %0d",
				name, first, frame_ts, second));
		if (second - first < timestamp_t'(FRAME_CYCLES))
			report_fail($sformatf("%s captures only %0d cycles apart", name, second - first));
	endtask

	task automatic run_test(input test_t t);
		reg_data_t got;
		int        soft0;
		int        clear0;
		case (t.op)
			OP_WRITE: begin
				spi_write(t.addr, t.data);
				for (int i = 0; i < N_CTRL; i++) begin
					if (CTRL_ADDR[i] == t.addr)
						port_exp[i] = t.exp_val;  // only the addressed port moves
				end
				for (int i = 0; i < N_CTRL; i++)
					compare_data($sformatf("%s port %h", t.name, CTRL_ADDR[i]), port_exp[i],
						port_word(CTRL_ADDR[i]));
			end
			OP_READ: begin
				spi_read(t.addr, got);
				compare_data(t.name, t.exp_val, got);
			end
			OP_PULSE: begin
				soft0  = soft_total;
				clear0 = clear_total;
				spi_write(t.addr, t.data);
				if (t.addr == ADDR_TRIG_SOFT) begin
					compare_data(t.name, t.exp_val, reg_data_t'(soft_total - soft0));
				end else begin
					compare_data(t.name, 16'd1, reg_data_t'(clear_total - clear0));
					compare_irq(t.name, irq_t'(t.exp_val), clear_last);
				end
			end
			OP_ABORT: begin
				cut_frame(t.addr);
				if (o_spi_miso_data_en)
					report_fail("MISO enable still high after an aborted frame");
			end
			default: check_timestamp(t.name);
		endcase
	endtask

	// ----------------------------------------
	// main sequence and watchdog
	// ----------------------------------------
	initial begin
		i_reset           = 1'b1;
		i_spi_clk         = 1'b0;  // spi clock idles low
		i_spi_cs_n        = 1'b1;
		i_spi_mosi        = 1'b0;
		i_fval            = 1'b0;
		i_line_status     = line_status_t'(xorshift());  // held for the whole run
		i_interrupt_state = irq_t'(xorshift());
		build_table();
		run_len = tests.size();
		repeat (5) @(negedge clk_gpif);
		i_reset = 1'b0;
		repeat (2) @(negedge clk_gpif);
		for (int i = 0; i < N_CTRL; i++)
			compare_data($sformatf("reset port %h", CTRL_ADDR[i]), '0, port_word(CTRL_ADDR[i]));
		compare_irq("reset interrupt clear", '0, o_interrupt_clear);
		compare_data("reset pulses", '0, reg_data_t'({o_trigger_soft, o_spi_miso_data_en}));
		foreach (tests[i])
			run_test(tests[i]);
		$display("RESULT: PASS");
		$finish;
	end

	initial begin
		wait (run_len > 0);
		#(run_len * 60 * 2 * SPI_HALF * 8 + 20_000);  // 60 spi bits per entry plus margin
		report_fail("run timed out before the test table finished");
	end

endmodule

//--- filelist.f
+incdir+tb
source/ctrl_pkg.sv
source/reg_bus_if.sv
source/spi_slave.sv
source/ctrl_reg_bank.sv
source/timestamp.sv
source/ctrl_channel.sv
tb/ctrl_channel_tb.sv

//--- Makefile
TOP := ctrl_channel_tb

all: run

build:
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module $(TOP) -Mdir obj_dir -o sim

run: build
	./obj_dir/sim

lint:
	verilator --lint-only --timing -Wall -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
